// ==== logic/platform_defines.svh ====
/*
 * Platform glue build options
 * Colour width, sound format, download address width and joystick remap
 */
`ifndef PLATFORM_DEFINES_SVH
`define PLATFORM_DEFINES_SVH

// Game colour channel width, 3 to 8
`define COLOR_W 4

// 1 for two's complement sound, 0 for offset binary
`define SIGNED_SND 0

// ROM download address width
`define ROM_ADDR_W 22

// 1 turns one fire button plus direction into three fire buttons
`define JOY_THREE_FIRE 0

`endif

// ==== logic/platform_pkg.sv ====
/*
 * Platform glue shared types
 * Output colour channel, joystick word, sound sample and video mode
 */
package platform_pkg;

    // Final 6-bit colour channel on the board DAC
    typedef logic [5:0] color6_t;

    // Conditioned joystick word
    // Bits 3:0 directions, 6:4 fire, rest zero
    typedef logic [31:0] joy_t;

    // One sound sample
    typedef logic [15:0] sample_t;

    // Output video mode
    typedef enum logic [1:0] {
        MODE_NATIVE = 2'd0, // 15 kHz RGB, composite sync
        MODE_SCAN2X = 2'd1, // Doubled RGB, separate sync
        MODE_YPBPR  = 2'd2  // Component, composite sync
    } video_mode_e;

endpackage

// ==== logic/joy_conditioner.sv ====
/*
 * Joystick conditioner
 * Registers both active-low joystick ports as positive-logic words.
 * Optional remap of one fire button plus left/right into three fire bits.
 */
`timescale 1ns/100ps
`include "platform_defines.svh"

module joy_conditioner import platform_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic [5:0] joya,   // Active low, player 1
    input  logic [5:0] joyb,   // Active low, player 2
    output joy_t       joy1,
    output joy_t       joy2
);

    // Same mapping for both players
    function automatic joy_t condition(input logic [5:0] j);
        joy_t w;
        w = '0;
        if (`JOY_THREE_FIRE != 0) begin
            w[3:0] = ~j[3:0];                 // Directions as is
            w[4]   = ~j[4] &  j[0] & ~j[1];   // Fire with left
            w[5]   = ~j[4] &  j[0] &  j[1];   // Fire alone
            w[6]   = ~j[4] & ~j[0] &  j[1];   // Fire with right
        end else begin
            w[5:0] = ~j;                      // Plain inversion
        end
        return w;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy1 <= '0;
            joy2 <= '0;
        end else begin
            joy1 <= condition(joya);
            joy2 <= condition(joyb);
        end
    end

endmodule

// ==== logic/sd_dac.sv ====
/*
 * One-bit sigma-delta DAC
 * First-order accumulator, the carry out is the output pulse.
 * Pulse density over 65536 cycles equals the offset-binary sample.
 */
`timescale 1ns/100ps
`include "platform_defines.svh"

module sd_dac import platform_pkg::*; (
    input  logic    clk_sys,
    input  logic    rst,
    input  sample_t pcm,
    output logic    dac_bit
);

    sample_t     pcm_u;   // Offset binary sample
    logic [15:0] acc;     // Error accumulator
    logic [16:0] sum;     // Carry in the top bit

    // Two's complement to offset binary is a flip of the sign bit
    assign pcm_u = {pcm[15] ^ 1'(`SIGNED_SND), pcm[14:0]};
    assign sum   = {1'b0, acc} + {1'b0, pcm_u};

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            acc     <= '0;
            dac_bit <= 1'b0;
        end else begin
            acc     <= sum[15:0];   // Keep the remainder
            dac_bit <= sum[16];     // One pulse per wrap
        end
    end

endmodule

// ==== logic/rgb2ypbpr.sv ====
/*
 * RGB to YPbPr converter
 * Fixed-point matrix on 6-bit channels, one registered stage.
 * Chroma is offset to mid-scale and every result is clamped to 6 bits.
 */
`timescale 1ns/100ps

module rgb2ypbpr import platform_pkg::*; (
    input  logic    clk_sys,
    input  logic    rst,
    input  color6_t red,
    input  color6_t green,
    input  color6_t blue,
    output color6_t y,
    output color6_t pb,
    output color6_t pr
);

    logic signed [15:0] r_x, g_x, b_x;           // Channels as signed
    logic signed [15:0] y_sum, pb_sum, pr_sum;   // Weighted sums
    logic signed [15:0] y_val, pb_val, pr_val;   // Scaled and offset

    // Saturate into the 6-bit range
    function automatic color6_t clamp6(input logic signed [15:0] v);
        if (v < 16'sd0)
            return 6'd0;
        else if (v > 16'sd63)
            return 6'd63;
        else
            return v[5:0];
    endfunction

    assign r_x = {10'd0, red};
    assign g_x = {10'd0, green};
    assign b_x = {10'd0, blue};

    // Weights in 1/256 for luma, 1/512 for chroma
    assign y_sum  = (16'sd77 * r_x) + (16'sd150 * g_x) + (16'sd29 * b_x);
    assign pb_sum = (16'sd128 * b_x) - (16'sd43 * r_x) - (16'sd85 * g_x);
    assign pr_sum = (16'sd128 * r_x) - (16'sd107 * g_x) - (16'sd21 * b_x);

    assign y_val  = y_sum >>> 8;                   // Truncated
    assign pb_val = 16'sd32 + (pb_sum >>> 9);      // Mid-scale offset
    assign pr_val = 16'sd32 + (pr_sum >>> 9);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            y  <= '0;
            pb <= '0;
            pr <= '0;
        end else begin
            y  <= clamp6(y_val);
            pb <= clamp6(pb_val);
            pr <= clamp6(pr_val);
        end
    end

endmodule

// ==== logic/video_out.sv ====
/*
 * Video output stage
 * Widens game colour to 6 bits, picks native or doubled video and forms
 * composite or separate sync. Optional YPbPr through the matrix.
 * Fixed 2-cycle latency from inputs to pins in every mode.
 */
`timescale 1ns/100ps
`include "platform_defines.svh"

module video_out import platform_pkg::*; (
    input  logic                clk_sys,
    input  logic                rst,
    input  video_mode_e         video_mode,
    input  logic [`COLOR_W-1:0] game_r,
    input  logic [`COLOR_W-1:0] game_g,
    input  logic [`COLOR_W-1:0] game_b,
    input  logic                hs,
    input  logic                vs,
    input  color6_t             scan2x_r,
    input  color6_t             scan2x_g,
    input  color6_t             scan2x_b,
    input  logic                scan2x_hs,
    input  logic                scan2x_vs,
    output color6_t             video_r,
    output color6_t             video_g,
    output color6_t             video_b,
    output logic                video_hs,
    output logic                video_vs
);

    color6_t     r_s1, g_s1, b_s1;   // Selected RGB
    color6_t     r_s2, g_s2, b_s2;   // Delayed RGB
    color6_t     y, pb, pr;          // Matrix output, stage two
    logic        hs_s1, vs_s1, hs_s2, vs_s2;
    video_mode_e mode_s1, mode_s2;   // Mode follows the pixels
    logic        hsync, vsync, csync;

    // Repeat the value and keep the top 6 bits
    function automatic color6_t widen(input logic [`COLOR_W-1:0] c);
        logic [3*`COLOR_W-1:0] rep;
        rep = {3{c}};
        return rep[3*`COLOR_W-1 -: 6];
    endfunction

    // Native sync is active low, doubler sync already positive
    assign hsync = (video_mode == MODE_NATIVE) ? ~hs : scan2x_hs;
    assign vsync = (video_mode == MODE_NATIVE) ? ~vs : scan2x_vs;
    assign csync = ~(hsync ^ vsync);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            {r_s1, g_s1, b_s1} <= '0;
            {r_s2, g_s2, b_s2} <= '0;
            {hs_s1, vs_s1, hs_s2, vs_s2} <= '0;
            mode_s1 <= MODE_NATIVE;
            mode_s2 <= MODE_NATIVE;
        end else begin
            mode_s1 <= video_mode;
            case (video_mode)
                MODE_SCAN2X: begin
                    r_s1  <= scan2x_r;
                    g_s1  <= scan2x_g;
                    b_s1  <= scan2x_b;
                    hs_s1 <= scan2x_hs;   // Separate sync for VGA
                    vs_s1 <= scan2x_vs;
                end
                MODE_YPBPR: begin
                    r_s1  <= scan2x_r;
                    g_s1  <= scan2x_g;
                    b_s1  <= scan2x_b;
                    hs_s1 <= csync;
                    vs_s1 <= 1'b1;
                end
                default: begin          // Native, SCART style
                    r_s1  <= widen(game_r);
                    g_s1  <= widen(game_g);
                    b_s1  <= widen(game_b);
                    hs_s1 <= csync;       // Composite on HS pin
                    vs_s1 <= 1'b1;        // High VS selects RGB
                end
            endcase
            // Second stage lines up with the matrix register
            r_s2    <= r_s1;
            g_s2    <= g_s1;
            b_s2    <= b_s1;
            hs_s2   <= hs_s1;
            vs_s2   <= vs_s1;
            mode_s2 <= mode_s1;
        end
    end

    rgb2ypbpr u_rgb2ypbpr (
        .clk_sys (clk_sys),
        .rst     (rst),
        .red     (r_s1),
        .green   (g_s1),
        .blue    (b_s1),
        .y       (y),
        .pb      (pb),
        .pr      (pr)
    );

    // Pr on red, Y on green, Pb on blue
    assign video_r  = (mode_s2 == MODE_YPBPR) ? pr : r_s2;
    assign video_g  = (mode_s2 == MODE_YPBPR) ? y  : g_s2;
    assign video_b  = (mode_s2 == MODE_YPBPR) ? pb : b_s2;
    assign video_hs = hs_s2;
    assign video_vs = vs_s2;

endmodule

// ==== logic/spi_rom_loader.sv ====
/*
 * SPI ROM loader
 * Mode-0 SPI slave, MSB first, oversampled on clk_sys.
 * Completed bytes sit in a one-entry register under valid/ready.
 * Address counts from 0 at each falling chip select.
 */
`timescale 1ns/100ps
`include "platform_defines.svh"

module spi_rom_loader import platform_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   spi_cs_n,
    input  logic                   spi_clk,
    input  logic                   spi_mosi,
    output logic [`ROM_ADDR_W-1:0] rom_addr,
    output logic [7:0]             rom_data,
    output logic                   rom_valid,
    input  logic                   rom_ready,
    output logic                   downloading,
    output logic                   rom_overrun
);

    logic [2:0] cs_sr;      // Two sync flops plus edge history
    logic [2:0] clk_sr;
    logic [1:0] mosi_sr;
    logic       cs_s, clk_rise, cs_fall;
    logic [2:0] bit_cnt;    // Bits taken in this byte
    logic [6:0] shift;      // Earlier bits, MSB first
    logic       byte_done;
    logic       accept;     // Byte taken this cycle
    logic       clr_pend;   // Address reset waits for held byte
    logic       cs_active;  // Registered chip select

    assign cs_s      = cs_sr[1];
    assign cs_fall   = cs_sr[2] & ~cs_sr[1];
    assign clk_rise  = ~clk_sr[2] & clk_sr[1];
    assign byte_done = clk_rise & ~cs_s & (bit_cnt == 3'd7);
    assign accept    = rom_valid & rom_ready;

    // Stays up until the last byte is taken
    assign downloading = cs_active | rom_valid;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cs_sr  <= 3'b111;   // Idle high, no false edge
            clk_sr <= 3'b000;
        end else begin
            cs_sr  <= {cs_sr[1:0], spi_cs_n};
            clk_sr <= {clk_sr[1:0], spi_clk};
        end
    end

    always_ff @(posedge clk_sys) begin
        mosi_sr <= {mosi_sr[0], spi_mosi};   // Same delay as clock
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            bit_cnt     <= '0;
            shift       <= '0;
            rom_addr    <= '0;
            rom_data    <= '0;
            rom_valid   <= 1'b0;
            rom_overrun <= 1'b0;
            clr_pend    <= 1'b0;
            cs_active   <= 1'b0;
        end else begin
            cs_active <= ~cs_s;
            if (cs_s) begin
                bit_cnt <= '0;                   // Realign on every burst
            end else if (clk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                shift   <= {shift[5:0], mosi_sr[1]};
            end
            if (cs_fall)
                rom_overrun <= 1'b0;             // New burst, fresh flag
            // Address moves on handshake or on a new burst
            if (accept) begin
                rom_addr <= (clr_pend | cs_fall) ? '0 : rom_addr + 1'b1;
                clr_pend <= 1'b0;
            end else if (cs_fall) begin
                if (rom_valid)
                    clr_pend <= 1'b1;            // Keep held address stable
                else
                    rom_addr <= '0;
            end
            if (byte_done) begin
                if (rom_valid && !rom_ready) begin
                    rom_overrun <= 1'b1;         // Byte lost, sticky
                end else begin
                    rom_data  <= {shift, mosi_sr[1]};
                    rom_valid <= 1'b1;
                end
            end else if (accept) begin
                rom_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/platform_base.sv ====
/*
 * Arcade platform base
 * Glue between the game core and the board: joystick conditioning,
 * status word, sigma-delta sound, video output and SPI ROM download.
 */
`timescale 1ns/100ps
`include "platform_defines.svh"

module platform_base import platform_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic [3:0]             vgactrl_en,   // Board video switches
    input  logic                   ypbpr,        // Component output pin
    // Joysticks
    input  logic [5:0]             JOYA,
    input  logic [5:0]             JOYB,
    output joy_t                   joystick1,
    output joy_t                   joystick2,
    // Sound
    input  sample_t                snd_left,
    input  sample_t                snd_right,
    output logic                   snd_pwm_left,
    output logic                   snd_pwm_right,
    // Game video
    input  logic [`COLOR_W-1:0]    game_r,
    input  logic [`COLOR_W-1:0]    game_g,
    input  logic [`COLOR_W-1:0]    game_b,
    input  logic                   LHBL,         // Not used here
    input  logic                   LVBL,         // Not used here
    input  logic                   hs,
    input  logic                   vs,
    // Scan doubler video
    input  color6_t                scan2x_r,
    input  color6_t                scan2x_g,
    input  color6_t                scan2x_b,
    input  logic                   scan2x_hs,
    input  logic                   scan2x_vs,
    output logic                   scan2x_enb,
    // Board video pins
    output color6_t                VIDEO_R,
    output color6_t                VIDEO_G,
    output color6_t                VIDEO_B,
    output logic                   VIDEO_HS,
    output logic                   VIDEO_VS,
    output logic [31:0]            status,
    // ROM download link
    input  logic                   SD_CS_N,
    input  logic                   SD_CLK,
    input  logic                   SD_MOSI,
    output logic [`ROM_ADDR_W-1:0] ioctl_addr,
    output logic [7:0]             ioctl_data,
    output logic                   ioctl_wr,
    input  logic                   rom_ready,
    output logic                   downloading,
    output logic                   rom_overrun
);

    video_mode_e video_mode;

    // Switch 0 low keeps native 15 kHz video
    assign video_mode = !vgactrl_en[0] ? MODE_NATIVE :
                        (ypbpr ? MODE_YPBPR : MODE_SCAN2X);
    assign scan2x_enb = vgactrl_en[0];

    assign status[2:0]   = 3'd0;
    assign status[3]     = vgactrl_en[1];   // Scanlines
    assign status[5:4]   = 2'd0;
    assign status[6]     = vgactrl_en[3];   // Test mode
    assign status[11:7]  = 5'd0;
    assign status[12]    = vgactrl_en[2];   // Screen flip
    assign status[31:13] = 19'd0;

    joy_conditioner u_joy (
        .clk_sys (clk_sys),
        .rst     (rst),
        .joya    (JOYA),
        .joyb    (JOYB),
        .joy1    (joystick1),
        .joy2    (joystick2)
    );

    sd_dac u_dac_left (
        .clk_sys (clk_sys),
        .rst     (rst),
        .pcm     (snd_left),
        .dac_bit (snd_pwm_left)
    );

    sd_dac u_dac_right (
        .clk_sys (clk_sys),
        .rst     (rst),
        .pcm     (snd_right),
        .dac_bit (snd_pwm_right)
    );

    video_out u_video (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .video_mode (video_mode),
        .game_r     (game_r),
        .game_g     (game_g),
        .game_b     (game_b),
        .hs         (hs),
        .vs         (vs),
        .scan2x_r   (scan2x_r),
        .scan2x_g   (scan2x_g),
        .scan2x_b   (scan2x_b),
        .scan2x_hs  (scan2x_hs),
        .scan2x_vs  (scan2x_vs),
        .video_r    (VIDEO_R),
        .video_g    (VIDEO_G),
        .video_b    (VIDEO_B),
        .video_hs   (VIDEO_HS),
        .video_vs   (VIDEO_VS)
    );

    spi_rom_loader u_loader (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .spi_cs_n    (SD_CS_N),
        .spi_clk     (SD_CLK),
        .spi_mosi    (SD_MOSI),
        .rom_addr    (ioctl_addr),
        .rom_data    (ioctl_data),
        .rom_valid   (ioctl_wr),
        .rom_ready   (rom_ready),
        .downloading (downloading),
        .rom_overrun (rom_overrun)
    );

endmodule

// ==== verif/platform_base_properties.sv ====
/*
 * Platform base properties
 * Bound to the top level. Checks the ROM byte handshake and the
 * idle state of the outputs right after reset.
 */
`timescale 1ns/100ps
`include "platform_defines.svh"

module platform_base_properties import platform_pkg::*; (
    input logic                   clk_sys,
    input logic                   rst,
    input logic [`ROM_ADDR_W-1:0] ioctl_addr,
    input logic [7:0]             ioctl_data,
    input logic                   ioctl_wr,
    input logic                   rom_ready,
    input logic                   downloading,
    input logic                   rom_overrun,
    input logic                   snd_pwm_left,
    input logic                   snd_pwm_right,
    input joy_t                   joystick1,
    input joy_t                   joystick2
);

    int assert_fails = 0;   // Read by the testbench at the end

    // Held byte and address frozen under backpressure
    a_hold_stable: assert property (@(posedge clk_sys) disable iff (rst)
        ioctl_wr && !rom_ready |=> $stable(ioctl_data) && $stable(ioctl_addr))
        else begin
            $error("ROM byte or address changed while waiting for rom_ready");
            assert_fails++;
        end

    // Idle loader cannot offer a byte in the next cycle
    a_wr_in_download: assert property (@(posedge clk_sys) disable iff (rst)
        !downloading |=> !ioctl_wr)
        else begin
            $error("ioctl_wr high right after downloading was low");
            assert_fails++;
        end

    // Everything quiet one cycle into reset
    a_reset_idle: assert property (@(posedge clk_sys)
        rst |=> !ioctl_wr && !downloading && !rom_overrun && !snd_pwm_left
            && !snd_pwm_right && joystick1 == '0 && joystick2 == '0)
        else begin
            $error("Outputs not idle in the cycle after reset");
            assert_fails++;
        end

endmodule

bind platform_base platform_base_properties u_props (.*);

// ==== verif/platform_base_tb.sv ====
/*
 * Platform base testbench
 * Table-driven checks of joystick, status, video, sound and ROM download.
 * Models the SPI master and a ROM sink with random backpressure.
 */
`timescale 1ns/100ps
`include "platform_defines.svh"

module platform_base_tb import platform_pkg::*; ();

    localparam int RST_CYC   = 10;
    localparam int JOY_N     = 6;
    localparam int VID_N     = 12;
    localparam int SND_N     = 5;
    localparam int SND_WIN   = 65536;   // Cycles per density count
    localparam int ROM_N     = 8;
    localparam int BYTE_CYC  = 64;      // 8 bits, 8 clocks each
    localparam int SPI_BYTES = ROM_N + 4 + 2;
    localparam int MAX_CYC   = 2 * (RST_CYC + JOY_N + 16 + VID_N + 2
                               + SND_N * (SND_WIN + 2))
                               + 2 * SPI_BYTES * BYTE_CYC + 4 * 64;

    logic clk_sys = 1'b0;
    logic rst;
    logic [3:0] vgactrl_en;
    logic ypbpr;
    logic [5:0] JOYA, JOYB;
    joy_t joystick1, joystick2;
    sample_t snd_left, snd_right;
    logic snd_pwm_left, snd_pwm_right;
    logic [`COLOR_W-1:0] game_r, game_g, game_b;
    logic LHBL, LVBL, hs, vs;
    color6_t scan2x_r, scan2x_g, scan2x_b;
    logic scan2x_hs, scan2x_vs, scan2x_enb;
    color6_t VIDEO_R, VIDEO_G, VIDEO_B;
    logic VIDEO_HS, VIDEO_VS;
    logic [31:0] status;
    logic SD_CS_N, SD_CLK, SD_MOSI;
    logic [`ROM_ADDR_W-1:0] ioctl_addr;
    logic [7:0] ioctl_data;
    logic ioctl_wr;
    logic rom_ready = 1'b0;
    logic downloading, rom_overrun;

    // Stimulus tables, joystick rows are {JOYA, JOYB}
    logic [11:0] joy_tab [JOY_N] = '{12'hfff, 12'h000, 12'hfe3, 12'h5aa, 12'hdef, 12'h3c1};
    logic [7:0]  rom_tab [ROM_N] = '{8'h3c, 8'ha5, 8'h00, 8'hff, 8'h81, 8'h7e, 8'h12, 8'hc9};
    sample_t     snd_tab [SND_N];
    // Video row: s2vs, s2hs, s2b, s2g, s2r, vs, hs, game b, g, r (8 bits each)
    logic [45:0] vid_tab [VID_N];

    int seed = 32'h6f2fa5a8;
    int checks = 0;
    int errors = 0;
    int t_checks = 0;
    int t_errs = 0;
    int cycle_cnt = 0;
    int ready_mode = 0;   // 0 low, 1 random, 2 high
    int ones_l, ones_r;
    logic [31:0] exp_status;
    logic [29:0] got_q [$];   // Accepted {address, data}

    platform_base dut0 (.*);

    always #5 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYC) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    // ROM sink backpressure
    always @(posedge clk_sys) begin
        #1;
        case (ready_mode)
            1: rom_ready = 1'($random(seed));
            2: rom_ready = 1'b1;
            default: rom_ready = 1'b0;
        endcase
    end

    // Mid-cycle view of what the next edge will accept
    always @(negedge clk_sys) begin
        if (ioctl_wr && rom_ready)
            got_q.push_back({ioctl_addr, ioctl_data});
    end

    task automatic step();
        @(posedge clk_sys);
        #1;                   // Drive just after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        t_checks++;
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            t_errs++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, t_checks, t_errs);
        checks += t_checks;
        errors += t_errs;
        t_checks = 0;
        t_errs = 0;
    endtask

    // Pressed buttons in positive logic, left is bit 1, right bit 0
    function automatic joy_t joy_ref(input logic [5:0] pins);
        logic [5:0] p;
        joy_t w;
        p = ~pins;
        w = '0;
        if (`JOY_THREE_FIRE != 0) begin
            w[3:0] = p[3:0];
            w[4] = p[4] & p[1] & ~p[0];
            w[5] = p[4] & ~p[1] & ~p[0];
            w[6] = p[4] & p[0] & ~p[1];
        end else begin
            w[5:0] = p;
        end
        return w;
    endfunction

    // MSB down, wrapping back to the top bit
    function automatic color6_t widen_ref(input logic [`COLOR_W-1:0] c);
        color6_t w;
        for (int i = 0; i < 6; i++)
            w[5 - i] = c[`COLOR_W - 1 - (i % `COLOR_W)];
        return w;
    endfunction

    // Returns {Pr, Y, Pb}
    function automatic logic [17:0] ypbpr_ref(input color6_t r, g, b);
        int ri, gi, bi, y, pb, pr;
        ri = int'(r);
        gi = int'(g);
        bi = int'(b);
        y  = (77 * ri + 150 * gi + 29 * bi) / 256;
        pb = 32 + ((128 * bi - 43 * ri - 85 * gi) >>> 9);
        pr = 32 + ((128 * ri - 107 * gi - 21 * bi) >>> 9);
        return {pr[5:0], y[5:0], pb[5:0]};
    endfunction

    // Returns {R, G, B, HS, VS} on the pins
    function automatic logic [19:0] video_ref(input logic [45:0] v, input int mode);
        logic hsync, vsync;
        if (mode == 0) begin
            hsync = ~v[24];
            vsync = ~v[25];
            return {widen_ref(v[0 +: `COLOR_W]), widen_ref(v[8 +: `COLOR_W]),
                    widen_ref(v[16 +: `COLOR_W]), ~(hsync ^ vsync), 1'b1};
        end else if (mode == 1) begin
            return {v[31:26], v[37:32], v[43:38], v[44], v[45]};
        end
        hsync = v[44];        // YPbPr always takes doubled sync
        vsync = v[45];
        return {ypbpr_ref(v[31:26], v[37:32], v[43:38]), ~(hsync ^ vsync), 1'b1};
    endfunction

    task automatic drive_video(input logic [45:0] v, input int mode);
        vgactrl_en[0] = (mode != 0);
        ypbpr = (mode == 2);
        game_r = v[0 +: `COLOR_W];
        game_g = v[8 +: `COLOR_W];
        game_b = v[16 +: `COLOR_W];
        hs = v[24];
        vs = v[25];
        scan2x_r = v[31:26];
        scan2x_g = v[37:32];
        scan2x_b = v[43:38];
        scan2x_hs = v[44];
        scan2x_vs = v[45];
    endtask

    // Mode 0, data set while SCK low, 4 clocks per half period
    task automatic spi_byte(input logic [7:0] data);
        for (int b = 7; b >= 0; b--) begin
            SD_MOSI = data[b];
            repeat (4) step();
            SD_CLK = 1'b1;
            repeat (4) step();
            SD_CLK = 1'b0;
        end
    endtask

    task automatic run_burst(input int first, input int count);
        SD_CS_N = 1'b0;
        repeat (4) step();    // Let CS through the synchroniser
        for (int k = 0; k < count; k++)
            spi_byte(rom_tab[first + k]);
        repeat (4) step();
        SD_CS_N = 1'b1;
        repeat (4) step();
    endtask

    task automatic check_burst(input int first, input int count, input string name);
        logic [29:0] e;
        check_value({name, " byte count"}, 32'(count), 32'(got_q.size()));
        for (int k = 0; k < count && k < got_q.size(); k++) begin
            e = got_q[k];
            check_value($sformatf("%s byte %0d address", name, k), 32'(k), 32'(e[29:8]));
            check_value($sformatf("%s byte %0d data", name, k),
                        32'(rom_tab[first + k]), 32'(e[7:0]));
        end
    endtask

    initial begin
        rst = 1'b1;
        vgactrl_en = 4'd0;
        ypbpr = 1'b0;
        JOYA = 6'h3f;         // Nothing pressed
        JOYB = 6'h3f;
        snd_left = '0;
        snd_right = '0;
        game_r = '0;
        game_g = '0;
        game_b = '0;
        LHBL = 1'b1;
        LVBL = 1'b1;
        hs = 1'b1;
        vs = 1'b1;
        scan2x_r = '0;
        scan2x_g = '0;
        scan2x_b = '0;
        scan2x_hs = 1'b0;
        scan2x_vs = 1'b0;
        SD_CS_N = 1'b1;
        SD_CLK = 1'b0;
        SD_MOSI = 1'b0;
        snd_tab[0] = 16'h0000;
        snd_tab[1] = 16'h4000;
        snd_tab[2] = 16'hc000;
        snd_tab[3] = 16'($random(seed));
        snd_tab[4] = 16'($random(seed));
        for (int i = 0; i < VID_N; i++)
            vid_tab[i] = 46'({$random(seed), $random(seed)});
        repeat (RST_CYC) step();
        rst = 1'b0;

        for (int i = 0; i < JOY_N; i++) begin
            JOYA = joy_tab[i][11:6];
            JOYB = joy_tab[i][5:0];
            step();           // One register stage
            check_value($sformatf("joy row %0d joystick1", i), joy_ref(JOYA), joystick1);
            check_value($sformatf("joy row %0d joystick2", i), joy_ref(JOYB), joystick2);
        end
        end_test("joystick");

        for (int v = 0; v < 16; v++) begin
            vgactrl_en = 4'(v);
            step();
            exp_status = '0;
            exp_status[3] = vgactrl_en[1];
            exp_status[6] = vgactrl_en[3];
            exp_status[12] = vgactrl_en[2];
            check_value($sformatf("status for switches %h", vgactrl_en), exp_status, status);
            check_value($sformatf("scan2x_enb for switches %h", vgactrl_en),
                        32'(vgactrl_en[0]), 32'(scan2x_enb));
        end
        end_test("status");

        // One row per cycle, row i shows up two edges later
        for (int i = 0; i < VID_N + 2; i++) begin
            step();
            if (i >= 2)
                check_value($sformatf("video row %0d mode %0d", i - 2, (i - 2) % 3),
                            32'(video_ref(vid_tab[i - 2], (i - 2) % 3)),
                            32'({VIDEO_R, VIDEO_G, VIDEO_B, VIDEO_HS, VIDEO_VS}));
            if (i < VID_N)
                drive_video(vid_tab[i], i % 3);
        end
        end_test("video");

        for (int s = 0; s < SND_N; s++) begin
            snd_left = snd_tab[s];
            snd_right = snd_tab[(s + 1) % SND_N];
            repeat (2) step();   // Output now follows the new sample
            ones_l = 0;
            ones_r = 0;
            for (int c = 0; c < SND_WIN; c++) begin
                if (snd_pwm_left)
                    ones_l++;
                if (snd_pwm_right)
                    ones_r++;
                step();
            end
            // Offset binary value of the sample
            check_value($sformatf("left ones for sample %h", snd_left),
                        32'(snd_left ^ ((`SIGNED_SND != 0) ? 16'h8000 : 16'h0000)),
                        32'(ones_l));
            check_value($sformatf("right ones for sample %h", snd_right),
                        32'(snd_right ^ ((`SIGNED_SND != 0) ? 16'h8000 : 16'h0000)),
                        32'(ones_r));
        end
        end_test("sound");

        ready_mode = 1;
        got_q.delete();
        run_burst(0, ROM_N);
        while (downloading)
            step();
        check_burst(0, ROM_N, "burst 1");
        check_value("burst 1 overrun", 32'd0, 32'(rom_overrun));
        got_q.delete();
        run_burst(4, 4);      // Addresses restart at 0
        while (downloading)
            step();
        check_burst(4, 4, "burst 2");
        end_test("rom download");

        // Sink stalled across two bytes
        ready_mode = 0;
        got_q.delete();
        SD_CS_N = 1'b0;
        repeat (4) step();
        spi_byte(rom_tab[0]);
        spi_byte(rom_tab[1]);
        repeat (4) step();
        check_value("overrun flag set", 32'd1, 32'(rom_overrun));
        check_value("overrun held valid", 32'd1, 32'(ioctl_wr));
        check_value("overrun held data", 32'(rom_tab[0]), 32'(ioctl_data));
        check_value("overrun held address", 32'd0, 32'(ioctl_addr));
        check_value("overrun downloading during burst", 32'd1, 32'(downloading));
        SD_CS_N = 1'b1;
        repeat (4) step();
        check_value("overrun sticky after CS high", 32'd1, 32'(rom_overrun));
        ready_mode = 2;
        while (downloading)
            step();
        check_value("overrun drained bytes", 32'd1, 32'(got_q.size()));
        SD_CS_N = 1'b0;
        repeat (4) step();
        check_value("overrun cleared by CS fall", 32'd0, 32'(rom_overrun));
        SD_CS_N = 1'b1;
        ready_mode = 0;
        repeat (4) step();
        end_test("overrun");

        errors += dut0.u_props.assert_fails;   // Bound property failures
        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/platform_pkg.sv
logic/joy_conditioner.sv
logic/sd_dac.sv
logic/rgb2ypbpr.sv
logic/video_out.sv
logic/spi_rom_loader.sv
logic/platform_base.sv
verif/platform_base_properties.sv
verif/platform_base_tb.sv

// ==== Makefile ====
# Verilator build and run for the platform base testbench

VERILATOR ?= verilator
TOP       ?= platform_base_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
